/* verilog/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // Bus data width, the lane steering is written for four byte lanes
    localparam int DATA_WIDTH = 32;
    localparam int LANES      = DATA_WIDTH / 8;

    // One data word on the bus and on the lanes
    typedef logic [DATA_WIDTH-1:0] word_t;

    // Wishbone select field, used as an access size code
    typedef logic [LANES-1:0] sel_t;

    // Legal size codes, anything else is an illegal size
    localparam sel_t SEL_WORD = 4'b1111;
    localparam sel_t SEL_HALF = 4'b0011;
    localparam sel_t SEL_BYTE = 4'b0001;

    // Per-lane write enables toward the bank
    typedef logic [LANES-1:0] lane_we_t;

    // Running byte offset inside one bus cycle, wraps modulo 256
    typedef logic [7:0] burst_off_t;

    // Controller FSM
    // ST_RESP and ST_ERR each last one cycle and drive ack or err
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RESP,
        ST_ERR
    } ctrl_state_t;

endpackage

`default_nettype wire

/* verilog/lane_port_if.sv */
`default_nettype none

interface lane_port_if import mem_pkg::*; #(
    parameter int DEPTH_WORDS = 256
) ();

    localparam int IDX_WIDTH = $clog2(DEPTH_WORDS);

    // Byte lanes to write this cycle
    lane_we_t             we;
    // Word index inside the bank
    logic [IDX_WIDTH-1:0] idx;
    // Store data already placed on its lanes
    word_t                wdata;
    // Registered read of the indexed word
    word_t                rdata;

    modport ctrl (
        output we,
        output idx,
        output wdata,
        input  rdata
    );

    modport bank (
        input  we,
        input  idx,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

/* verilog/byte_lane_bank.sv */
`default_nettype none

module byte_lane_bank import mem_pkg::*; #(
    parameter int DEPTH_WORDS = 256
) (
    input wire         clk,
    lane_port_if.bank  lane
);

    // One byte-wide array per lane
    logic [7:0] lane_mem [LANES][DEPTH_WORDS];

    // Read register, one byte per lane
    logic [7:0] rd_byte [LANES];

    genvar k;
    generate
        for (k = 0; k < LANES; k++) begin : g_lane

            // Each lane writes only its own byte of the word
            always_ff @(posedge clk) begin
                if (lane.we[k]) begin
                    lane_mem[k][lane.idx] <= lane.wdata[8*k +: 8];
                end
            end

            // Read every clock, old data on a same-cycle write
            always_ff @(posedge clk) begin
                rd_byte[k] <= lane_mem[k][lane.idx];
            end

        end
    endgenerate

    // Gather the lanes back into one word
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            lane.rdata[8*i +: 8] = rd_byte[i];
        end
    end

endmodule

`default_nettype wire

/* verilog/mem_access_ctrl.sv */
`default_nettype none

module mem_access_ctrl import mem_pkg::*; #(
    parameter int ADDR_WIDTH  = 32,
    parameter int DEPTH_WORDS = 256
) (
    input  wire                  clk,
    input  wire                  i_rst_n,

    // Wishbone classic slave
    input  wire                  i_wb_cyc,
    input  wire                  i_wb_stb,
    input  wire                  i_wb_we,
    input  wire [ADDR_WIDTH-1:0] i_wb_adr,
    input  wire word_t           i_wb_dat,
    input  wire sel_t            i_wb_sel,
    output word_t                o_wb_dat,
    output logic                 o_wb_ack,
    output logic                 o_wb_err,

    // Lanes toward the storage bank
    lane_port_if.ctrl            lane
);

    localparam int IDX_WIDTH = $clog2(DEPTH_WORDS);

    ctrl_state_t state_q;
    burst_off_t  off_q;
    logic        err_q;
    logic        rd_q;
    logic [1:0]  rd_off_q;
    sel_t        rd_sel_q;

    logic [ADDR_WIDTH-1:0] eff_adr;
    logic [1:0]            byte_off;
    burst_off_t            size_bytes;
    logic                  sel_ok;
    logic                  misalign;
    logic                  strobe;
    logic                  bad;
    logic                  accept;
    lane_we_t              lane_mask;
    word_t                 rd_shift;
    word_t                 rd_data;

    // Size decode from the select code
    always_comb begin
        sel_ok     = 1'b1;
        size_bytes = '0;
        case (i_wb_sel)
            SEL_WORD: size_bytes = 8'd4;
            SEL_HALF: size_bytes = 8'd2;
            SEL_BYTE: size_bytes = 8'd1;
            default:  sel_ok     = 1'b0;
        endcase
    end

    // Effective address includes the running burst offset
    assign eff_adr  = i_wb_adr + ADDR_WIDTH'(off_q);
    assign byte_off = eff_adr[1:0];

    // Words need 4-byte alignment, halfwords an even address
    assign misalign = ((i_wb_sel == SEL_WORD) && (byte_off != 2'b00)) ||
                      ((i_wb_sel == SEL_HALF) && byte_off[0]);

    // A strobe is only taken in idle, so at most one every two cycles
    assign strobe = i_wb_cyc && i_wb_stb && (state_q == ST_IDLE);
    assign bad    = err_q || !sel_ok || misalign;
    assign accept = strobe && !bad;

    // Store steering onto the byte lanes
    assign lane_mask  = i_wb_sel << byte_off;
    assign lane.we    = (accept && i_wb_we) ? lane_mask : '0;
    assign lane.wdata = i_wb_dat << {byte_off, 3'b000};
    // Upper index bits are dropped, so the address wraps on the bank
    assign lane.idx   = eff_adr[IDX_WIDTH+1:2];

    // Response FSM
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (strobe) begin
                        state_q <= bad ? ST_ERR : ST_RESP;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Burst offset and sticky error live for one bus cycle
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            off_q <= '0;
            err_q <= 1'b0;
            rd_q  <= 1'b0;
        end else begin
            if (!i_wb_cyc) begin
                off_q <= '0;
                err_q <= 1'b0;
            end else if (strobe) begin
                if (bad) begin
                    err_q <= 1'b1;
                end else begin
                    off_q <= off_q + size_bytes;
                end
            end
            if (strobe) begin
                rd_q <= !i_wb_we;
            end
        end
    end

    // Offset and size for the read that comes back next cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            rd_off_q <= byte_off;
            rd_sel_q <= i_wb_sel;
        end
    end

    // Load steering, shift down then zero-extend to the size
    always_comb begin
        rd_shift = lane.rdata >> {rd_off_q, 3'b000};
        case (rd_sel_q)
            SEL_WORD: rd_data = rd_shift;
            SEL_HALF: rd_data = rd_shift & word_t'(16'hffff);
            default:  rd_data = rd_shift & word_t'(8'hff);
        endcase
    end

    assign o_wb_ack = (state_q == ST_RESP);
    assign o_wb_err = (state_q == ST_ERR);
    // Data bus stays at zero outside a read acknowledge
    assign o_wb_dat = (o_wb_ack && rd_q) ? rd_data : '0;

endmodule

`default_nettype wire

/* verilog/mem_subsys_top.sv */
`default_nettype none

module mem_subsys_top import mem_pkg::*; #(
    parameter int ADDR_WIDTH  = 32,
    parameter int DEPTH_WORDS = 256
) (
    input  wire                  clk,
    input  wire                  i_rst_n,

    // Wishbone classic slave port
    input  wire                  i_wb_cyc,
    input  wire                  i_wb_stb,
    input  wire                  i_wb_we,
    input  wire [ADDR_WIDTH-1:0] i_wb_adr,
    input  wire word_t           i_wb_dat,
    input  wire sel_t            i_wb_sel,
    output word_t                o_wb_dat,
    output logic                 o_wb_ack,
    output logic                 o_wb_err
);

    // Controller to bank lanes
    lane_port_if #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) lane_bus ();

    // Bus slave, size steering and burst offset
    mem_access_ctrl #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .DEPTH_WORDS (DEPTH_WORDS)
    ) u_ctrl (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_we  (i_wb_we),
        .i_wb_adr (i_wb_adr),
        .i_wb_dat (i_wb_dat),
        .i_wb_sel (i_wb_sel),
        .o_wb_dat (o_wb_dat),
        .o_wb_ack (o_wb_ack),
        .o_wb_err (o_wb_err),
        .lane     (lane_bus.ctrl)
    );

    // Byte-lane storage
    byte_lane_bank #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) u_bank (
        .clk  (clk),
        .lane (lane_bus.bank)
    );

endmodule

`default_nettype wire

/* testbench/mem_subsys_properties.sv */
`default_nettype none

module mem_subsys_properties import mem_pkg::*; (
    input wire           clk,
    input wire           i_rst_n,
    input wire           i_cyc,
    input wire           i_stb,
    input wire           i_we,
    input wire           i_ack,
    input wire           i_err,
    input wire lane_we_t i_lane_we
);

    // One kind of response per strobe
    assert property (@(posedge clk) disable iff (!i_rst_n) !(i_ack && i_err))
        else $error("ack and err are high together");

    assert property (@(posedge clk) disable iff (!i_rst_n) i_ack |=> !i_ack)
        else $error("ack is held longer than one cycle");

    assert property (@(posedge clk) disable iff (!i_rst_n) i_err |=> !i_err)
        else $error("err is held longer than one cycle");

    // First edge after reset release
    assert property (@(posedge clk) $rose(i_rst_n) |-> (!i_ack && !i_err))
        else $error("response right after reset release");

    // Lanes only write while the bus presents a write strobe
    assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_lane_we != '0) |-> (i_cyc && i_stb && i_we))
        else $error("lane write without a write strobe on the bus");

    // A lane write is always answered with ack and never with err
    assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_lane_we != '0) |=> i_ack)
        else $error("lane write that was not acknowledged");

endmodule

bind mem_access_ctrl mem_subsys_properties u_props (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_cyc     (i_wb_cyc),
    .i_stb     (i_wb_stb),
    .i_we      (i_wb_we),
    .i_ack     (o_wb_ack),
    .i_err     (o_wb_err),
    .i_lane_we (lane.we)
);

`default_nettype wire

/* testbench/tb_mem_subsys.sv */
`default_nettype none

module tb_mem_subsys import mem_pkg::*; ();

    localparam int N_RAND  = 200;
    localparam int N_BURST = 20;
    localparam int N_ERR   = 30;
    // Upper bound on transfers over all phases
    localparam int N_XFERS        = 256 + 2 * N_RAND + 16 * N_BURST + 4 * N_ERR;
    localparam int TIMEOUT_CYCLES = 4 * N_XFERS + 200;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    word_t       wb_dat_w;
    word_t       wb_dat_r;
    sel_t        wb_sel;
    logic        wb_ack;
    logic        wb_err;

    // Reference model, one entry per bank byte
    logic [7:0] model_mem [1024];
    burst_off_t model_off;
    logic       model_err;
    integer     seed;
    int         mismatches;
    int         other_errs;

    mem_subsys_top UUT (
        .clk      (clk),
        .i_rst_n  (rst_n),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_we  (wb_we),
        .i_wb_adr (wb_adr),
        .i_wb_dat (wb_dat_w),
        .i_wb_sel (wb_sel),
        .o_wb_dat (wb_dat_r),
        .o_wb_ack (wb_ack),
        .o_wb_err (wb_err)
    );

    always #5 clk = ~clk;

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s expected %08h, actual %08h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s expected %0b, actual %0b", $time, name, exp, act);
        end
    endtask

    // Bytes per access, 0 for an illegal select code
    function automatic int access_size(input sel_t sel);
        case (sel)
            4'b1111: return 4;
            4'b0011: return 2;
            4'b0001: return 1;
            default: return 0;
        endcase
    endfunction

    function automatic word_t next_rand();
        return word_t'($random(seed));
    endfunction

    function automatic sel_t pick_legal_sel();
        word_t r;
        r = next_rand();
        case (r % 3)
            32'd0:   return 4'b1111;
            32'd1:   return 4'b0011;
            default: return 4'b0001;
        endcase
    endfunction

    function automatic logic [31:0] align_to(input logic [31:0] adr, input sel_t sel);
        return adr & ~(32'(access_size(sel) - 1));
    endfunction

    // One strobe inside the open bus cycle, model updated first
    task automatic xfer(input logic we, input logic [31:0] adr, input word_t dat,
                        input sel_t sel);
        logic [31:0] eff;
        int          size;
        logic        bad;
        word_t       exp_dat;
        int          waited;
        logic        got;
        eff     = adr + 32'(model_off);
        size    = access_size(sel);
        bad     = model_err || (size == 0) || (size == 4 && eff[1:0] != 2'b00) ||
                  (size == 2 && eff[0]);
        exp_dat = '0;
        if (bad) begin
            model_err = 1'b1;
        end else begin
            for (int i = 0; i < size; i++) begin
                if (we) begin
                    model_mem[eff[9:0] + 10'(i)] = dat[8*i +: 8];
                end else begin
                    exp_dat[8*i +: 8] = model_mem[eff[9:0] + 10'(i)];
                end
            end
            model_off = model_off + burst_off_t'(size);
        end
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        wb_sel   = sel;
        got      = 1'b0;
        waited   = 0;
        while (!got && waited < 2) begin
            @(negedge clk);
            waited++;
            got = wb_ack || wb_err;
        end
        if (!got) begin
            other_errs++;
            $display("no response within 2 cycles to the strobe at address %08h", adr);
        end else begin
            if (waited != 1) begin
                other_errs++;
                $display("response came after %0d cycles instead of 1 at %0t", waited, $time);
            end
            check_bit("o_wb_ack", !bad, wb_ack);
            check_bit("o_wb_err", bad, wb_err);
            check_word("o_wb_dat", exp_dat, wb_dat_r);
        end
        wb_stb = 1'b0;
    endtask

    // Drop cyc, offset and sticky error restart
    task automatic end_cycle();
        wb_cyc    = 1'b0;
        wb_we     = 1'b0;
        model_off = '0;
        model_err = 1'b0;
    endtask

    initial begin
        sel_t        sel;
        sel_t        rsel;
        logic [31:0] adr;
        word_t       r;
        int          len;
        seed       = 32'h92b076f2;
        mismatches = 0;
        other_errs = 0;
        clk        = 1'b0;
        rst_n      = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        wb_sel     = '0;
        model_off  = '0;
        model_err  = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("o_wb_ack", 1'b0, wb_ack);
        check_bit("o_wb_err", 1'b0, wb_err);
        check_word("o_wb_dat", '0, wb_dat_r);

        // Known contents everywhere
        for (int w = 0; w < 256; w++) begin
            adr = 32'(w * 4);
            xfer(1'b1, adr, {2'b10, adr[9:0], ~adr[9:0], adr[9:0]}, 4'b1111);
            end_cycle();
        end

        // Single transfers, read back through an alias above the bank depth
        repeat (N_RAND) begin
            sel = pick_legal_sel();
            adr = align_to(next_rand(), sel);
            xfer(1'b1, adr, next_rand(), sel);
            end_cycle();
            rsel = pick_legal_sel();
            r    = next_rand();
            xfer(1'b0, align_to({r[31:10], adr[9:2], r[1:0]}, rsel), '0, rsel);
            end_cycle();
        end

        // Multi-transfer cycles of one size
        repeat (N_BURST) begin
            sel = pick_legal_sel();
            adr = next_rand() & 32'hffff_fffc;
            len = 2 + int'(next_rand() % 7);
            for (int i = 0; i < len; i++) begin
                xfer(1'b1, adr, next_rand(), sel);
            end
            end_cycle();
            for (int i = 0; i < len; i++) begin
                xfer(1'b0, adr, '0, sel);
            end
            end_cycle();
        end

        // Misaligned and illegal accesses, then a clean cycle
        repeat (N_ERR) begin
            r   = next_rand();
            adr = r & 32'hffff_fffc;
            case (next_rand() % 3)
                32'd0: begin
                    sel      = 4'b1111;
                    adr[1:0] = (r[1:0] == 2'b00) ? 2'b10 : r[1:0];
                end
                32'd1: begin
                    sel    = 4'b0011;
                    adr[0] = 1'b1;
                end
                default: begin
                    do begin
                        sel = sel_t'(next_rand());
                    end while (access_size(sel) != 0);
                end
            endcase
            xfer(1'b1, adr, next_rand(), sel);
            xfer(1'b1, adr & 32'hffff_fffc, next_rand(), 4'b1111);
            xfer(1'b0, adr & 32'hffff_fffc, '0, 4'b0001);
            end_cycle();
            xfer(1'b0, adr & 32'hffff_fffc, '0, 4'b1111);
            end_cycle();
        end

        @(negedge clk);
        $display("error counts: %0d mismatches, %0d other errors", mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles before the tests ended", TIMEOUT_CYCLES);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* mem_subsys.f */
verilog/mem_pkg.sv
verilog/lane_port_if.sv
verilog/byte_lane_bank.sv
verilog/mem_access_ctrl.sv
verilog/mem_subsys_top.sv
testbench/mem_subsys_properties.sv
testbench/tb_mem_subsys.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f mem_subsys.f \
    --top-module tb_mem_subsys

./obj_dir/Vtb_mem_subsys | tee sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "all tests passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
